/* rtl/dcache_pkg.sv */
package dcache_pkg;

	// address and data geometry
	localparam int ADDR_W   = 64;
	localparam int WORD_W   = 64;
	localparam int LINE_W   = 128;

	// 4 ways of 64 sets, index is addr[9:4], tag is addr[63:10]
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 64;
	localparam int INDEX_W  = 6;
	localparam int TAG_W    = 54;
	localparam int OFFSET_W = 4;

	// backing memory, indexed by addr[11:4]
	localparam int MEM_LINES   = 256;
	localparam int MEM_LATENCY = 2;

	// register map
	localparam int CFG_ADDR_W = 2;
	localparam logic [CFG_ADDR_W-1:0] REG_CTRL   = 2'd0;
	localparam logic [CFG_ADDR_W-1:0] REG_LIMIT  = 2'd1;
	localparam logic [CFG_ADDR_W-1:0] REG_HITS   = 2'd2;
	localparam logic [CFG_ADDR_W-1:0] REG_MISSES = 2'd3;

	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		FILL,
		RESP
	} ctrl_state_t;

endpackage

/* rtl/dcache_data_sram.sv */
`timescale 1ns/1ns

module dcache_data_sram (
	input  logic                             clk,
	input  logic                             en,
	input  logic                             we,
	input  logic [dcache_pkg::INDEX_W-1:0]   index,
	input  logic [dcache_pkg::LINE_W-1:0]    wline,
	output logic [dcache_pkg::LINE_W-1:0]    rline
);
	import dcache_pkg::*;

	// one line per set
	logic [LINE_W-1:0] mem [NUM_SETS];

	// single port: a write leaves rline untouched
	// rline holds its value while en is low
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wline;
			end else begin
				rline <= mem[index];
			end
		end
	end

endmodule

/* rtl/dcache_tag_array.sv */
`timescale 1ns/1ns

module dcache_tag_array (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [dcache_pkg::ADDR_W-1:0]    lookup_addr,
	output logic [dcache_pkg::NUM_WAYS-1:0]  way_hit,
	input  logic                             fill_en,
	input  logic [dcache_pkg::NUM_WAYS-1:0]  fill_way,
	input  logic                             snoop_en,
	input  logic [dcache_pkg::ADDR_W-1:0]    snoop_addr
);
	import dcache_pkg::*;

	logic [TAG_W-1:0]    tags [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] valid [NUM_WAYS];

	logic [INDEX_W-1:0]  lk_index;
	logic [TAG_W-1:0]    lk_tag;
	logic [INDEX_W-1:0]  sn_index;
	logic [TAG_W-1:0]    sn_tag;

	// split both addresses into set and tag
	assign lk_index = lookup_addr[OFFSET_W +: INDEX_W];
	assign lk_tag   = lookup_addr[ADDR_W-1 -: TAG_W];
	assign sn_index = snoop_addr[OFFSET_W +: INDEX_W];
	assign sn_tag   = snoop_addr[ADDR_W-1 -: TAG_W];

	// compare all ways of the set in parallel
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = valid[w][lk_index] && (tags[w][lk_index] == lk_tag);
		end
	end

	// fill writes the lookup tag into the chosen way
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (fill_en && fill_way[w]) begin
				tags[w][lk_index] <= lk_tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid[w] <= '0;
			end
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (fill_en && fill_way[w]) begin
					valid[w][lk_index] <= 1'b1;
				end
				// snoop comes last so a clear beats a fill of the same entry
				if (snoop_en && (tags[w][sn_index] == sn_tag)) begin
					valid[w][sn_index] <= 1'b0;
				end
			end
		end
	end

	// the controller only fills after a miss, so a line never lands in two ways
	assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit))
		else $error("tag array: line present in more than one way");

endmodule

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ns

module dcache_ctrl (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             req_valid,
	output logic                             req_ready,
	input  logic [dcache_pkg::ADDR_W-1:0]    req_addr,
	output logic                             rsp_valid,
	input  logic                             rsp_ready,
	output logic [dcache_pkg::WORD_W-1:0]    rsp_data,
	input  logic                             wr_valid,
	output logic                             wr_ready,
	output logic [dcache_pkg::ADDR_W-1:0]    lookup_addr,
	input  logic [dcache_pkg::NUM_WAYS-1:0]  way_hit,
	output logic                             fill_en,
	output logic [dcache_pkg::NUM_WAYS-1:0]  fill_way,
	output logic [dcache_pkg::NUM_WAYS-1:0]  sram_en,
	output logic                             sram_we,
	output logic [dcache_pkg::INDEX_W-1:0]   sram_index,
	output logic [dcache_pkg::LINE_W-1:0]    sram_wline,
	input  logic [dcache_pkg::LINE_W-1:0]    sram_rline0,
	input  logic [dcache_pkg::LINE_W-1:0]    sram_rline1,
	input  logic [dcache_pkg::LINE_W-1:0]    sram_rline2,
	input  logic [dcache_pkg::LINE_W-1:0]    sram_rline3,
	output logic                             mem_rd_valid,
	output logic [dcache_pkg::ADDR_W-1:0]    mem_rd_addr,
	input  logic                             mem_rd_done,
	input  logic [dcache_pkg::LINE_W-1:0]    mem_rd_line,
	input  logic                             cache_en,
	input  logic [dcache_pkg::ADDR_W-1:0]    cache_limit,
	output logic                             hit_pulse,
	output logic                             miss_pulse
);
	import dcache_pkg::*;

	ctrl_state_t         state;
	logic [ADDR_W-1:0]   addr_q;
	logic [NUM_WAYS-1:0] hit_way_q;
	logic [NUM_WAYS-1:0] victim;
	logic [LINE_W-1:0]   line_q;
	logic [LINE_W-1:0]   line_sel;
	logic                hit;
	logic                alloc;

	// writes win over requests, both only enter from IDLE
	assign req_ready = (state == IDLE) && !wr_valid;
	assign wr_ready  = (state == IDLE);

	// with the cache disabled every lookup is a miss
	assign hit   = cache_en && (way_hit != '0);
	// lines above the limit are never allocated
	assign alloc = cache_en && (addr_q <= cache_limit);

	assign lookup_addr = addr_q;
	assign hit_pulse   = (state == LOOKUP) && hit;
	assign miss_pulse  = (state == LOOKUP) && !hit;

	// memory read issued from LOOKUP on a miss
	assign mem_rd_valid = miss_pulse;
	assign mem_rd_addr  = addr_q;

	// fill lands together with the returning line
	assign fill_en  = (state == FILL) && mem_rd_done && alloc;
	assign fill_way = victim;

	// hit reads the matching way, fill writes the victim
	assign sram_en    = hit_pulse ? way_hit : (fill_en ? victim : '0);
	assign sram_we    = (state == FILL);
	assign sram_index = addr_q[OFFSET_W +: INDEX_W];
	assign sram_wline = mem_rd_line;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			hit_way_q <= '0;
			victim    <= NUM_WAYS'(1);
		end else begin
			case (state)
				IDLE: begin
					if (req_valid && req_ready) begin
						state <= LOOKUP;
					end
				end
				LOOKUP: begin
					// zero selects the holding register in RESP
					hit_way_q <= hit ? way_hit : '0;
					state     <= hit ? RESP : FILL;
				end
				FILL: begin
					if (mem_rd_done) begin
						// victim rotates once per allocated fill
						if (alloc) begin
							victim <= {victim[NUM_WAYS-2:0], victim[NUM_WAYS-1]};
						end
						state <= RESP;
					end
				end
				RESP: begin
					if (rsp_ready) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// request address and fetched line
	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			addr_q <= req_addr;
		end
		if ((state == FILL) && mem_rd_done) begin
			line_q <= mem_rd_line;
		end
	end

	always_comb begin
		case (hit_way_q)
			4'b0001: line_sel = sram_rline0;
			4'b0010: line_sel = sram_rline1;
			4'b0100: line_sel = sram_rline2;
			4'b1000: line_sel = sram_rline3;
			default: line_sel = line_q;
		endcase
	end

	// addr bit 3 picks the upper or lower word
	assign rsp_valid = (state == RESP);
	assign rsp_data  = addr_q[OFFSET_W-1] ? line_sel[LINE_W-1 -: WORD_W] : line_sel[WORD_W-1:0];

	// held response must not move, SRAM outputs included
	assert property (@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
		else $error("ctrl: response changed under back-pressure");

	// the line comes back after the fixed latency while FILL still waits for it
	assert property (@(posedge clk) disable iff (rst)
		mem_rd_valid |-> ##MEM_LATENCY (mem_rd_done && (state == FILL)))
		else $error("ctrl: memory line returned late or outside FILL");

endmodule

/* rtl/dcache_cfg_regs.sv */
`timescale 1ns/1ns

module dcache_cfg_regs (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               cfg_we,
	input  logic [dcache_pkg::CFG_ADDR_W-1:0]  cfg_addr,
	input  logic [dcache_pkg::WORD_W-1:0]      cfg_wdata,
	output logic [dcache_pkg::WORD_W-1:0]      cfg_rdata,
	output logic                               cache_en,
	output logic [dcache_pkg::ADDR_W-1:0]      cache_limit,
	input  logic                               hit_pulse,
	input  logic                               miss_pulse
);
	import dcache_pkg::*;

	logic [WORD_W-1:0] hits;
	logic [WORD_W-1:0] misses;

	always_ff @(posedge clk) begin
		if (rst) begin
			// enabled, whole address space cacheable
			cache_en    <= 1'b1;
			cache_limit <= '1;
			hits        <= '0;
			misses      <= '0;
		end else begin
			if (cfg_we && (cfg_addr == REG_CTRL)) begin
				cache_en <= cfg_wdata[0];
			end
			if (cfg_we && (cfg_addr == REG_LIMIT)) begin
				cache_limit <= cfg_wdata[ADDR_W-1:0];
			end
			// any write clears, clear beats a same-cycle event
			if (cfg_we && (cfg_addr == REG_HITS)) begin
				hits <= '0;
			end else if (hit_pulse) begin
				hits <= hits + 1'b1;
			end
			if (cfg_we && (cfg_addr == REG_MISSES)) begin
				misses <= '0;
			end else if (miss_pulse) begin
				misses <= misses + 1'b1;
			end
		end
	end

	// combinational read
	always_comb begin
		case (cfg_addr)
			REG_CTRL:   cfg_rdata = {{(WORD_W-1){1'b0}}, cache_en};
			REG_LIMIT:  cfg_rdata = cache_limit;
			REG_HITS:   cfg_rdata = hits;
			default:    cfg_rdata = misses;
		endcase
	end

endmodule

/* rtl/line_mem.sv */
`timescale 1ns/1ns

module line_mem (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           rd_valid,
	input  logic [dcache_pkg::ADDR_W-1:0]  rd_addr,
	output logic                           rd_done,
	output logic [dcache_pkg::LINE_W-1:0]  rd_line,
	input  logic                           wr_en,
	input  logic [dcache_pkg::ADDR_W-1:0]  wr_addr,
	input  logic [dcache_pkg::WORD_W-1:0]  wr_data
);
	import dcache_pkg::*;

	logic [LINE_W-1:0]              mem [MEM_LINES];
	logic [MEM_LATENCY-1:0]         done_pipe;
	logic [LINE_W-1:0]              line_pipe [MEM_LATENCY];
	logic [$clog2(MEM_LINES)-1:0]   rd_idx;
	logic [$clog2(MEM_LINES)-1:0]   wr_idx;

	// line index from addr[11:4], upper bits alias
	assign rd_idx = rd_addr[OFFSET_W +: $clog2(MEM_LINES)];
	assign wr_idx = wr_addr[OFFSET_W +: $clog2(MEM_LINES)];

	// word write, addr bit 3 selects the half
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MEM_LINES; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[wr_idx][wr_addr[OFFSET_W-1] * WORD_W +: WORD_W] <= wr_data;
		end
	end

	// fixed latency delay line
	always_ff @(posedge clk) begin
		if (rst) begin
			done_pipe <= '0;
		end else begin
			done_pipe <= {done_pipe[MEM_LATENCY-2:0], rd_valid};
		end
	end

	always_ff @(posedge clk) begin
		line_pipe[0] <= mem[rd_idx];
		for (int s = 1; s < MEM_LATENCY; s++) begin
			line_pipe[s] <= line_pipe[s-1];
		end
	end

	assign rd_done = done_pipe[MEM_LATENCY-1];
	assign rd_line = line_pipe[MEM_LATENCY-1];

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ns

module dcache_top (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               req_valid,
	output logic                               req_ready,
	input  logic [dcache_pkg::ADDR_W-1:0]      req_addr,
	output logic                               rsp_valid,
	input  logic                               rsp_ready,
	output logic [dcache_pkg::WORD_W-1:0]      rsp_data,
	input  logic                               wr_valid,
	output logic                               wr_ready,
	input  logic [dcache_pkg::ADDR_W-1:0]      wr_addr,
	input  logic [dcache_pkg::WORD_W-1:0]      wr_data,
	input  logic                               cfg_we,
	input  logic [dcache_pkg::CFG_ADDR_W-1:0]  cfg_addr,
	input  logic [dcache_pkg::WORD_W-1:0]      cfg_wdata,
	output logic [dcache_pkg::WORD_W-1:0]      cfg_rdata
);
	import dcache_pkg::*;

	logic [ADDR_W-1:0]   lookup_addr;
	logic [NUM_WAYS-1:0] way_hit;
	logic                fill_en;
	logic [NUM_WAYS-1:0] fill_way;
	logic [NUM_WAYS-1:0] sram_en;
	logic                sram_we;
	logic [INDEX_W-1:0]  sram_index;
	logic [LINE_W-1:0]   sram_wline;
	logic [LINE_W-1:0]   sram_rline [NUM_WAYS];
	logic                mem_rd_valid;
	logic [ADDR_W-1:0]   mem_rd_addr;
	logic                mem_rd_done;
	logic [LINE_W-1:0]   mem_rd_line;
	logic                cache_en;
	logic [ADDR_W-1:0]   cache_limit;
	logic                hit_pulse;
	logic                miss_pulse;
	logic                wr_accept;

	// accepted write goes to memory and snoops the tags in the same cycle
	assign wr_accept = wr_valid && wr_ready;

	dcache_ctrl i_ctrl (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data),
		.wr_valid(wr_valid), .wr_ready(wr_ready),
		.lookup_addr(lookup_addr), .way_hit(way_hit),
		.fill_en(fill_en), .fill_way(fill_way),
		.sram_en(sram_en), .sram_we(sram_we), .sram_index(sram_index),
		.sram_wline(sram_wline),
		.sram_rline0(sram_rline[0]), .sram_rline1(sram_rline[1]),
		.sram_rline2(sram_rline[2]), .sram_rline3(sram_rline[3]),
		.mem_rd_valid(mem_rd_valid), .mem_rd_addr(mem_rd_addr),
		.mem_rd_done(mem_rd_done), .mem_rd_line(mem_rd_line),
		.cache_en(cache_en), .cache_limit(cache_limit),
		.hit_pulse(hit_pulse), .miss_pulse(miss_pulse)
	);

	dcache_cfg_regs i_cfg (
		.clk(clk), .rst(rst),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
		.cache_en(cache_en), .cache_limit(cache_limit),
		.hit_pulse(hit_pulse), .miss_pulse(miss_pulse)
	);

	dcache_tag_array i_tags (
		.clk(clk), .rst(rst),
		.lookup_addr(lookup_addr), .way_hit(way_hit),
		.fill_en(fill_en), .fill_way(fill_way),
		.snoop_en(wr_accept), .snoop_addr(wr_addr)
	);

	line_mem i_mem (
		.clk(clk), .rst(rst),
		.rd_valid(mem_rd_valid), .rd_addr(mem_rd_addr),
		.rd_done(mem_rd_done), .rd_line(mem_rd_line),
		.wr_en(wr_accept), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	// one data array per way
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		dcache_data_sram i_sram (
			.clk(clk), .en(sram_en[w]), .we(sram_we),
			.index(sram_index), .wline(sram_wline), .rline(sram_rline[w])
		);
	end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic rst
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// reset held over the first two rising edges
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#10;
		rst = 1'b0;
	end

endmodule

/* bench/tb_checker.sv */
`timescale 1ns/1ns

module tb_checker (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               req_valid,
	input  logic                               req_ready,
	input  logic [dcache_pkg::ADDR_W-1:0]      req_addr,
	input  logic                               rsp_valid,
	input  logic                               rsp_ready,
	input  logic [dcache_pkg::WORD_W-1:0]      rsp_data,
	input  logic                               wr_valid,
	input  logic                               wr_ready,
	input  logic [dcache_pkg::ADDR_W-1:0]      wr_addr,
	input  logic [dcache_pkg::WORD_W-1:0]      wr_data,
	input  logic                               cfg_we,
	input  logic [dcache_pkg::CFG_ADDR_W-1:0]  cfg_addr,
	input  logic [dcache_pkg::WORD_W-1:0]      cfg_wdata,
	input  logic [dcache_pkg::WORD_W-1:0]      cfg_rdata,
	input  logic                               cfg_rd,
	input  logic [dcache_pkg::WORD_W-1:0]      cfg_exp,
	output int                                 errors,
	output int                                 checks,
	output int                                 pending
);
	import dcache_pkg::*;

	// model of backing memory and cache contents
	logic [LINE_W-1:0] mem_m [MEM_LINES];
	logic [TAG_W-1:0]  tag_m [NUM_WAYS][NUM_SETS];
	logic [LINE_W-1:0] data_m [NUM_WAYS][NUM_SETS];
	logic              vld_m [NUM_WAYS][NUM_SETS];
	int                victim_m;
	logic              en_m;
	logic [ADDR_W-1:0] limit_m;
	logic [WORD_W-1:0] hits_m;
	logic [WORD_W-1:0] misses_m;
	// words expected on the response port, oldest first
	logic [WORD_W-1:0] exp_q [$];
	logic [WORD_W-1:0] expected;
	// a read is outstanding from its acceptance until its response is taken
	logic              busy;

	task automatic reset_model();
		for (int i = 0; i < MEM_LINES; i++) begin
			mem_m[i] = '0;
		end
		for (int w = 0; w < NUM_WAYS; w++) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				vld_m[w][s] = 1'b0;
				tag_m[w][s] = '0;
			end
		end
		victim_m = 0;
		en_m     = 1'b1;
		limit_m  = '1;
		hits_m   = '0;
		misses_m = '0;
		busy     = 1'b0;
		exp_q.delete();
	endtask

	// word write goes to memory, any way holding that tag in the set drops out
	task automatic apply_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
		logic [INDEX_W-1:0] idx;
		idx = addr[9:4];
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (tag_m[w][idx] == addr[63:10]) begin
				vld_m[w][idx] = 1'b0;
			end
		end
		if (addr[3]) begin
			mem_m[addr[11:4]][127:64] = data;
		end else begin
			mem_m[addr[11:4]][63:0] = data;
		end
	endtask

	// hit or miss, allocation below the limit, victim rotates per fill
	task automatic predict_read(input logic [ADDR_W-1:0] addr);
		logic [INDEX_W-1:0] idx;
		logic [LINE_W-1:0]  line;
		int                 way;
		idx = addr[9:4];
		way = -1;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (en_m && vld_m[w][idx] && (tag_m[w][idx] == addr[63:10])) begin
				way = w;
			end
		end
		if (way >= 0) begin
			hits_m = hits_m + 64'd1;
			line   = data_m[way][idx];
		end else begin
			misses_m = misses_m + 64'd1;
			line     = mem_m[addr[11:4]];
			if (en_m && (addr <= limit_m)) begin
				tag_m[victim_m][idx]  = addr[63:10];
				data_m[victim_m][idx] = line;
				vld_m[victim_m][idx]  = 1'b1;
				victim_m = (victim_m + 1) % NUM_WAYS;
			end
		end
		// bit 3 picks the upper word
		exp_q.push_back(addr[3] ? line[127:64] : line[63:0]);
	endtask

	function automatic logic [WORD_W-1:0] model_reg(input logic [CFG_ADDR_W-1:0] a);
		case (a)
			REG_CTRL:  return {{(WORD_W-1){1'b0}}, en_m};
			REG_LIMIT: return limit_m;
			REG_HITS:  return hits_m;
			default:   return misses_m;
		endcase
	endfunction

	// everything sampled at the edge, before the DUT registers move
	always @(posedge clk) begin
		if (rst) begin
			reset_model();
		end else begin
			// ready only while idle and no write is offered
			checks++;
			if (req_ready !== (!busy && !wr_valid)) begin
				$display("FAIL %0t: req_ready %b, expected %b", $time, req_ready,
					!busy && !wr_valid);
				errors++;
			end
			if (wr_ready !== !busy) begin
				$display("FAIL %0t: wr_ready %b, expected %b", $time, wr_ready, !busy);
				errors++;
			end
			if (cfg_rd) begin
				checks++;
				if (cfg_rdata !== model_reg(cfg_addr)) begin
					$display("FAIL %0t: reg %0d read %h, model %h", $time, cfg_addr, cfg_rdata,
						model_reg(cfg_addr));
					errors++;
				end
				if (cfg_rdata !== cfg_exp) begin
					$display("FAIL %0t: reg %0d read %h, table %h", $time, cfg_addr, cfg_rdata,
						cfg_exp);
					errors++;
				end
			end
			// held data must match on every cycle until it is taken
			if (rsp_valid) begin
				checks++;
				if (exp_q.size() == 0) begin
					$display("response at %0t arrived with no request outstanding", $time);
					errors++;
				end else begin
					expected = exp_q[0];
					if (rsp_data !== expected) begin
						$display("FAIL %0t: read data %h, expected %h", $time, rsp_data, expected);
						errors++;
					end
					if (rsp_ready) begin
						expected = exp_q.pop_front();
						busy     = 1'b0;
					end
				end
			end
			if (wr_valid && wr_ready) begin
				apply_write(wr_addr, wr_data);
			end
			if (req_valid && req_ready) begin
				predict_read(req_addr);
				busy = 1'b1;
			end
			if (cfg_we) begin
				// counters clear on any write
				case (cfg_addr)
					REG_CTRL:  en_m = cfg_wdata[0];
					REG_LIMIT: limit_m = cfg_wdata;
					REG_HITS:  hits_m = '0;
					default:   misses_m = '0;
				endcase
			end
		end
		pending = exp_q.size();
	end

endmodule

/* bench/tb_top.sv */
`timescale 1ns/1ns

module tb_top;
	import dcache_pkg::*;

	// step kinds of the stimulus table
	localparam logic [1:0] OP_READ   = 2'd0;
	localparam logic [1:0] OP_WRITE  = 2'd1;
	localparam logic [1:0] OP_CFG_WR = 2'd2;
	localparam logic [1:0] OP_CFG_RD = 2'd3;

	logic                  clk;
	logic                  rst;
	logic                  req_valid;
	logic                  req_ready;
	logic [ADDR_W-1:0]     req_addr;
	logic                  rsp_valid;
	logic                  rsp_ready;
	logic [WORD_W-1:0]     rsp_data;
	logic                  wr_valid;
	logic                  wr_ready;
	logic [ADDR_W-1:0]     wr_addr;
	logic [WORD_W-1:0]     wr_data;
	logic                  cfg_we;
	logic [CFG_ADDR_W-1:0] cfg_addr;
	logic [WORD_W-1:0]     cfg_wdata;
	logic [WORD_W-1:0]     cfg_rdata;
	logic                  cfg_rd;
	logic [WORD_W-1:0]     cfg_exp;
	int                    errors;
	int                    checks;
	int                    pending;
	int                    fails;
	int                    cycles;
	int                    cycle_limit;
	int unsigned           rnd;

	// table: kind, address, write data or expected register value
	logic [1:0]            step_op [$];
	logic [ADDR_W-1:0]     step_addr [$];
	logic [WORD_W-1:0]     step_data [$];

	tb_clock i_clk (.clk(clk), .rst(rst));

	dcache_top i_dut (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data),
		.wr_valid(wr_valid), .wr_ready(wr_ready), .wr_addr(wr_addr), .wr_data(wr_data),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
	);

	tb_checker i_chk (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data),
		.wr_valid(wr_valid), .wr_ready(wr_ready), .wr_addr(wr_addr), .wr_data(wr_data),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
		.cfg_rd(cfg_rd), .cfg_exp(cfg_exp),
		.errors(errors), .checks(checks), .pending(pending)
	);

	task automatic add_step(input logic [1:0] op, input logic [ADDR_W-1:0] addr,
		input logic [WORD_W-1:0] data);
		step_op.push_back(op);
		step_addr.push_back(addr);
		step_data.push_back(data);
	endtask

	task automatic build_table();
		// first read of a line misses, later reads hit
		add_step(OP_WRITE, 64'h100, 64'h1111_0000_0000_0100);
		add_step(OP_WRITE, 64'h108, 64'h2222_0000_0000_0108);
		add_step(OP_WRITE, 64'h230, 64'h3333_0000_0000_0230);
		add_step(OP_READ, 64'h100, 64'h0);
		add_step(OP_READ, 64'h108, 64'h0);
		add_step(OP_READ, 64'h230, 64'h0);
		add_step(OP_READ, 64'h230, 64'h0);
		add_step(OP_CFG_RD, 64'(REG_HITS), 64'd2);
		add_step(OP_CFG_RD, 64'(REG_MISSES), 64'd2);
		// write to a cached line invalidates it
		add_step(OP_WRITE, 64'h108, 64'h4444_0000_0000_0108);
		add_step(OP_READ, 64'h108, 64'h0);
		add_step(OP_READ, 64'h100, 64'h0);
		// clear the hit counter, only later hits count
		add_step(OP_CFG_WR, 64'(REG_HITS), 64'h0);
		add_step(OP_READ, 64'h100, 64'h0);
		add_step(OP_CFG_RD, 64'(REG_HITS), 64'd1);
		add_step(OP_CFG_RD, 64'(REG_MISSES), 64'd3);
		// five lines in set 2, 0x1020 aliases 0x020 in memory
		add_step(OP_WRITE, 64'h020, 64'h5555_0000_0000_0020);
		add_step(OP_WRITE, 64'h428, 64'h6666_0000_0000_0428);
		add_step(OP_WRITE, 64'h820, 64'h7777_0000_0000_0820);
		add_step(OP_WRITE, 64'hc28, 64'h8888_0000_0000_0c28);
		add_step(OP_READ, 64'h020, 64'h0);
		add_step(OP_READ, 64'h420, 64'h0);
		add_step(OP_READ, 64'h820, 64'h0);
		add_step(OP_READ, 64'hc20, 64'h0);
		add_step(OP_READ, 64'h1020, 64'h0);
		add_step(OP_READ, 64'h020, 64'h0);
		add_step(OP_READ, 64'h428, 64'h0);
		add_step(OP_READ, 64'hc20, 64'h0);
		add_step(OP_READ, 64'h1020, 64'h0);
		add_step(OP_CFG_RD, 64'(REG_HITS), 64'd3);
		add_step(OP_CFG_RD, 64'(REG_MISSES), 64'd10);
		// no allocation above the limit
		add_step(OP_CFG_WR, 64'(REG_LIMIT), 64'h7ff);
		add_step(OP_READ, 64'h900, 64'h0);
		add_step(OP_READ, 64'h900, 64'h0);
		add_step(OP_READ, 64'h230, 64'h0);
		// disabled cache misses on every read
		add_step(OP_CFG_WR, 64'(REG_CTRL), 64'h0);
		add_step(OP_READ, 64'h230, 64'h0);
		add_step(OP_READ, 64'h108, 64'h0);
		// re-enabled with full range, 0x900 allocates now
		add_step(OP_CFG_WR, 64'(REG_CTRL), 64'h1);
		add_step(OP_CFG_WR, 64'(REG_LIMIT), 64'hffff_ffff_ffff_ffff);
		add_step(OP_READ, 64'h900, 64'h0);
		add_step(OP_READ, 64'h900, 64'h0);
		add_step(OP_CFG_RD, 64'(REG_CTRL), 64'd1);
		add_step(OP_CFG_RD, 64'(REG_LIMIT), 64'hffff_ffff_ffff_ffff);
		add_step(OP_CFG_RD, 64'(REG_HITS), 64'd5);
		add_step(OP_CFG_RD, 64'(REG_MISSES), 64'd15);
		// a cleared miss counter counts only later misses
		add_step(OP_CFG_WR, 64'(REG_MISSES), 64'h0);
		add_step(OP_READ, 64'h230, 64'h0);
		add_step(OP_READ, 64'h100, 64'h0);
		add_step(OP_CFG_RD, 64'(REG_MISSES), 64'd1);
		add_step(OP_CFG_RD, 64'(REG_HITS), 64'd6);
	endtask

	// each step starts and ends 10 ns after a rising edge
	task automatic apply_step(input logic [1:0] op, input logic [ADDR_W-1:0] addr,
		input logic [WORD_W-1:0] data);
		case (op)
			OP_WRITE: begin
				wr_valid = 1'b1;
				wr_addr  = addr;
				wr_data  = data;
				@(posedge clk);
				while (!wr_ready) begin
					@(posedge clk);
				end
				#10;
				wr_valid = 1'b0;
			end
			OP_READ: begin
				req_valid = 1'b1;
				req_addr  = addr;
				@(posedge clk);
				while (!req_ready) begin
					@(posedge clk);
				end
				#10;
				req_valid = 1'b0;
				// wait out the response under back-pressure
				@(posedge clk);
				while (!(rsp_valid && rsp_ready)) begin
					@(posedge clk);
				end
				#10;
			end
			OP_CFG_WR: begin
				cfg_we    = 1'b1;
				cfg_addr  = addr[CFG_ADDR_W-1:0];
				cfg_wdata = data;
				@(posedge clk);
				#10;
				cfg_we = 1'b0;
			end
			default: begin
				cfg_addr = addr[CFG_ADDR_W-1:0];
				cfg_exp  = data;
				cfg_rd   = 1'b1;
				@(posedge clk);
				#10;
				cfg_rd = 1'b0;
			end
		endcase
	endtask

	// random back-pressure, ready about three cycles in four
	initial begin
		rnd = $urandom(32'hd157f10b);
		rsp_ready = 1'b1;
		forever begin
			@(posedge clk);
			#10;
			rnd = $urandom;
			rsp_ready = (rnd % 4) != 0;
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > cycle_limit) begin
				$display("timeout: run did not finish within %0d cycles", cycle_limit);
				$display("Regression failed");
				$finish;
			end
		end
	end

	initial begin
		req_valid = 1'b0;
		req_addr  = '0;
		wr_valid  = 1'b0;
		wr_addr   = '0;
		wr_data   = '0;
		cfg_we    = 1'b0;
		cfg_addr  = '0;
		cfg_wdata = '0;
		cfg_rd    = 1'b0;
		cfg_exp   = '0;
		build_table();
		cycle_limit = step_op.size() * 20 + 50;
		@(negedge rst);
		@(posedge clk);
		#10;
		for (int k = 0; k < step_op.size(); k++) begin
			apply_step(step_op[k], step_addr[k], step_data[k]);
		end
		repeat (4) @(posedge clk);
		#10;
		fails = errors;
		if (pending != 0) begin
			$display("%0d read responses never came back", pending);
			fails++;
		end
		$display("errors: %0d, checks: %0d, steps: %0d", fails, checks, step_op.size());
		if (fails == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
rtl/dcache_pkg.sv
rtl/dcache_data_sram.sv
rtl/dcache_tag_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_cfg_regs.sv
rtl/line_mem.sv
rtl/dcache_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_top
FILELIST  = vlog.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJDIR)
